/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --assert --timing -f spiMaster.f --top-module spiMasterTb
	@out="$$(./obj_dir/VspiMasterTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --assert --timing -f spiMaster.f --top-module spiMasterTb

clean:
	rm -rf obj_dir

/* logic/byteFifo.sv */
`timescale 1ns/100ps
`include "spiMaster_defs.svh"

module byteFifo (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  logic [`SPI_DATAWIDTH-1:0] pushData,
    input  logic                     pop,
    output logic [`SPI_DATAWIDTH-1:0] popData,
    output logic                     full,
    output logic                     empty,
    output logic                     overflow
);

    logic [`SPI_DATAWIDTH-1:0]  mem [`SPI_FIFODEPTH];
    logic [`SPI_PTRWIDTH-1:0]   wrPtr;
    logic [`SPI_PTRWIDTH-1:0]   rdPtr;
    logic [`SPI_PTRWIDTH:0]     count;      // one extra bit for full
    logic                       doPush;
    logic                       doPop;

    assign full  = (count == (`SPI_PTRWIDTH+1)'(`SPI_FIFODEPTH));
    assign empty = (count == '0);

    // a pop in the same cycle frees the slot for a push
    assign doPop    = pop && !empty;
    assign doPush   = push && (!full || pop);
    assign overflow = push && full && !pop; // byte dropped

    assign popData = mem[rdPtr];           // head visible without pop

    always_ff @(posedge clk) begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

endmodule

/* logic/hostBusPkg.sv */
package hostBusPkg;

    // host command opcodes
    typedef enum logic [2:0] {
        OP_WRITE_TX    = 3'd0,  // push byte into tx fifo
        OP_READ_RX     = 3'd1,  // pop byte from rx fifo
        OP_SET_CONFIG  = 3'd2,  // polarity, phase, order, divider
        OP_SET_SELECT  = 3'd3,  // drive ssN from wdata[0]
        OP_READ_STATUS = 3'd4   // status byte, clears overrun
    } hostOp;

    // bit positions in the status byte
    typedef enum logic [2:0] {
        ST_TX_FULL  = 3'd0,
        ST_TX_EMPTY = 3'd1,
        ST_RX_FULL  = 3'd2,
        ST_RX_EMPTY = 3'd3,
        ST_OVERRUN  = 3'd4,
        ST_IDLE     = 3'd5
    } statusBit;

endpackage

/* logic/hostPort.sv */
`timescale 1ns/100ps
`include "spiMaster_defs.svh"

module hostPort import hostBusPkg::*, spiCorePkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  hostOp                    op,
    input  logic [`SPI_DATAWIDTH-1:0] wdata,
    input  logic [`SPI_DIVWIDTH-1:0]  cfgDiv,
    output logic                     ack,
    output logic [`SPI_DATAWIDTH-1:0] rdata,
    input  logic                     txFull,
    input  logic                     txEmpty,
    input  logic                     rxFull,
    input  logic                     rxEmpty,
    input  logic [`SPI_DATAWIDTH-1:0] rxData,
    input  logic                     overflow,
    input  logic                     idle,
    output logic                     txPush,
    output logic [`SPI_DATAWIDTH-1:0] txData,
    output logic                     rxPop,
    output logic                     clockPolarity,
    output logic                     clockPhase,
    output bitOrder                  order,
    output logic [`SPI_DIVWIDTH-1:0]  divider,
    output logic                     ssN
);

    typedef enum logic [1:0] {
        HS_WAIT, // waiting for req
        HS_DONE, // command executed, ack next edge
        HS_ACK   // ack high until req falls
    } handshakeState;

    handshakeState              hsState;
    logic                       ready;    // command can run this cycle
    logic                       exec;     // one-cycle command strobe
    logic                       overrun;  // sticky rx drop flag
    logic [`SPI_DATAWIDTH-1:0]  status;

    // back-pressure per opcode
    always_comb begin
        case (op)
            OP_WRITE_TX:   ready = !txFull;
            OP_READ_RX:    ready = !rxEmpty;
            OP_SET_CONFIG: ready = idle && txEmpty; // no launch pending either
            default:       ready = 1'b1;
        endcase
    end

    assign exec   = (hsState == HS_WAIT) && req && ready;
    assign txPush = exec && (op == OP_WRITE_TX);
    assign rxPop  = exec && (op == OP_READ_RX);
    assign txData = wdata;                  // fifo captures on txPush
    assign ack    = (hsState == HS_ACK);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hsState <= HS_WAIT;
        end else begin
            case (hsState)
                HS_WAIT: if (exec) hsState <= HS_DONE;
                HS_DONE: hsState <= HS_ACK;
                HS_ACK:  if (!req) hsState <= HS_WAIT; // host released
                default: hsState <= HS_WAIT;
            endcase
        end
    end

    // configuration and select registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clockPolarity <= 1'b0;
            clockPhase    <= 1'b0;
            order         <= MSB_FIRST;
            divider       <= '0;
            ssN           <= 1'b1;        // slave deselected
        end else if (exec && op == OP_SET_CONFIG) begin
            clockPolarity <= wdata[0];
            clockPhase    <= wdata[1];
            order         <= bitOrder'(wdata[2]);
            divider       <= cfgDiv;
        end else if (exec && op == OP_SET_SELECT) begin
            ssN <= wdata[0];
        end
    end

    // a dropped byte wins over a same-cycle status read
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            overrun <= 1'b0;
        else if (overflow)
            overrun <= 1'b1;
        else if (exec && op == OP_READ_STATUS)
            overrun <= 1'b0;
    end

    always_comb begin
        status              = '0;
        status[ST_TX_FULL]  = txFull;
        status[ST_TX_EMPTY] = txEmpty;
        status[ST_RX_FULL]  = rxFull;
        status[ST_RX_EMPTY] = rxEmpty;
        status[ST_OVERRUN]  = overrun;
        status[ST_IDLE]     = idle;
    end

    // read data latched with the command, held through ack
    always_ff @(posedge clk) begin
        if (exec && op == OP_READ_RX)
            rdata <= rxData;              // show-ahead head
        else if (exec && op == OP_READ_STATUS)
            rdata <= status;
    end

endmodule

/* logic/sclkDivider.sv */
`timescale 1ns/100ps
`include "spiMaster_defs.svh"

module sclkDivider (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    busy,
    input  logic [`SPI_DIVWIDTH-1:0] divider,
    output logic                    finalCycle
);

    logic [`SPI_DIVWIDTH-1:0] count;

    // down-counter, one pulse every divider+1 clocks
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            count <= '0;
        else if (!busy || count == '0)
            count <= divider;          // preload while idle, reload on wrap
        else
            count <= count - 1'b1;
    end

    // idle engine gets a pulse every cycle so it can launch at once
    assign finalCycle = !busy || (count == '0);

endmodule

/* logic/spiController.sv */
`timescale 1ns/100ps
`include "spiMaster_defs.svh"

// phase 0 sets mosi up half a period early, samples on the leading edge
//   and drives the next bit on the trailing edge
// phase 1 drives mosi with the leading edge and samples on the trailing edge
// polarity only sets the level sclk rests at between bursts
// fifo read and write strobes never fire in the same state

module spiController import spiCorePkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clockPolarity,
    input  logic                     clockPhase,
    input  bitOrder                  order,
    input  logic                     finalCycle,
    input  logic [`SPI_DATAWIDTH-1:0] dataIn,
    output logic [`SPI_DATAWIDTH-1:0] dataOut,
    input  logic                     coreTxEmpty,
    output logic                     coreWrite,
    output logic                     coreRead,
    output logic                     idle,
    input  logic                     miso,
    output logic                     mosi,
    output logic                     sclk
);

    localparam int CNTWIDTH = $clog2(`SPI_DATAWIDTH) + 1;

    spiState                    state;
    spiState                    nextState;
    logic [CNTWIDTH-1:0]        bitCounter;      // counts from 1
    logic [CNTWIDTH-1:0]        bitCounterValue;
    logic [`SPI_DATAWIDTH-1:0]  dataOutNext;
    logic                       finalBit;
    logic                       mosiNext;
    logic                       sclkNext;
    logic                       coreReadNext;
    logic                       coreWriteNext;
    logic                       idleNext;

    // control registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            bitCounter <= CNTWIDTH'(1);
            sclk       <= 1'b0;     // follows polarity from IDLE on
            mosi       <= 1'b0;
            coreRead   <= 1'b0;
            coreWrite  <= 1'b0;
            idle       <= 1'b1;
        end else begin
            state      <= nextState;
            bitCounter <= bitCounterValue;
            sclk       <= sclkNext;
            mosi       <= mosiNext;
            coreRead   <= coreReadNext;
            coreWrite  <= coreWriteNext;
            idle       <= idleNext;
        end
    end

    // shared tx/rx shift register is only meaningful once loaded
    always_ff @(posedge clk) begin
        dataOut <= dataOutNext;
    end

    assign finalBit = (bitCounter >= CNTWIDTH'(`SPI_DATAWIDTH));

    always_comb begin
        nextState       = IDLE;
        bitCounterValue = bitCounter;   // hold
        dataOutNext     = dataOut;      // hold
        sclkNext        = sclk;         // hold
        mosiNext        = mosi;         // hold
        coreWriteNext   = 1'b0;
        coreReadNext    = 1'b0;
        idleNext        = 1'b0;

        case (state)
            IDLE: begin
                idleNext        = 1'b1;
                bitCounterValue = CNTWIDTH'(1);
                sclkNext        = clockPolarity;   // rest level
                if (finalCycle && !coreTxEmpty) begin
                    dataOutNext  = dataIn;         // head of tx fifo
                    coreReadNext = 1'b1;           // pop it
                end
                nextState = (finalCycle && !coreTxEmpty) ? START : IDLE;
            end

            // like OUTPUT but the first edge only exists in phase 1
            START: begin
                if (finalCycle) begin
                    if (clockPhase)
                        sclkNext = !sclk;
                    case (order)
                        LSB_FIRST: mosiNext = dataOut[0];
                        default:   mosiNext = dataOut[`SPI_DATAWIDTH-1];
                    endcase
                end
                nextState = finalCycle ? SAMPLE : START;
            end

            OUTPUT: begin
                if (finalCycle) begin
                    sclkNext = !sclk;              // drive edge
                    case (order)
                        LSB_FIRST: mosiNext = dataOut[0];
                        default:   mosiNext = dataOut[`SPI_DATAWIDTH-1];
                    endcase
                end
                nextState = finalCycle ? SAMPLE : OUTPUT;  // then a sample half-period
            end

            SAMPLE: begin
                if (finalCycle) begin
                    sclkNext = !sclk;              // sample edge
                    case (order)
                        LSB_FIRST: dataOutNext = {miso, dataOut[`SPI_DATAWIDTH-1:1]};
                        default:   dataOutNext = {dataOut[`SPI_DATAWIDTH-2:0], miso};
                    endcase
                    if (finalBit) begin
                        bitCounterValue = CNTWIDTH'(1);
                        coreWriteNext   = 1'b1;    // full byte into rx fifo
                    end else begin
                        bitCounterValue = bitCounter + 1'b1;
                    end
                end
                if (finalCycle)
                    nextState = finalBit ? CHECK : OUTPUT;
                else
                    nextState = SAMPLE;
            end

            // chain the next byte without a gap if one is waiting
            CHECK: begin
                if (!coreTxEmpty) begin
                    dataOutNext  = dataIn;
                    coreReadNext = 1'b1;
                end
                nextState = !coreTxEmpty ? OUTPUT : STOP;
            end

            // close the last half-period before reporting idle
            STOP: begin
                if (finalCycle)
                    sclkNext = clockPolarity;
                nextState = finalCycle ? IDLE : STOP;
            end

            default: nextState = IDLE;
        endcase
    end

endmodule

/* logic/spiCorePkg.sv */
package spiCorePkg;

    // bit engine states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,  // waiting for tx data
        START  = 3'd1,  // first bit of a burst
        OUTPUT = 3'd2,  // drive mosi
        SAMPLE = 3'd3,  // capture miso
        CHECK  = 3'd4,  // byte done so chain another or stop
        STOP   = 3'd5   // trailing half-period
    } spiState;

    // shift direction on the wire
    typedef enum logic {
        MSB_FIRST = 1'b0,
        LSB_FIRST = 1'b1
    } bitOrder;

endpackage

/* logic/spiMaster.sv */
`timescale 1ns/100ps
`include "spiMaster_defs.svh"

module spiMaster import hostBusPkg::*, spiCorePkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  hostOp                    op,
    input  logic [`SPI_DATAWIDTH-1:0] wdata,
    input  logic [`SPI_DIVWIDTH-1:0]  cfgDiv,
    output logic                     ack,
    output logic [`SPI_DATAWIDTH-1:0] rdata,
    input  logic                     miso,
    output logic                     mosi,
    output logic                     sclk,
    output logic                     ssN
);

    logic                       txPush;
    logic [`SPI_DATAWIDTH-1:0]  txData;
    logic [`SPI_DATAWIDTH-1:0]  txHead;     // show-ahead byte for the engine
    logic                       txFull;
    logic                       txEmpty;
    logic                       rxPop;
    logic [`SPI_DATAWIDTH-1:0]  rxData;
    logic                       rxFull;
    logic                       rxEmpty;
    logic                       rxOverflow;
    logic                       coreRead;
    logic                       coreWrite;
    logic [`SPI_DATAWIDTH-1:0]  coreData;   // received byte
    logic                       clockPolarity;
    logic                       clockPhase;
    bitOrder                    order;
    logic [`SPI_DIVWIDTH-1:0]   divider;
    logic                       finalCycle;
    logic                       idle;

    hostPort hostPort (
        .clk, .reset, .req, .op, .wdata, .cfgDiv, .ack, .rdata,
        .txFull, .txEmpty, .rxFull, .rxEmpty, .rxData,
        .overflow (rxOverflow),
        .idle, .txPush, .txData, .rxPop,
        .clockPolarity, .clockPhase, .order, .divider, .ssN
    );

    // host is back-pressured on full, so tx never drops a byte
    byteFifo txFifo (
        .clk, .reset,
        .push (txPush), .pushData (txData), .pop (coreRead),
        .popData (txHead), .full (txFull), .empty (txEmpty), .overflow ()
    );

    byteFifo rxFifo (
        .clk, .reset,
        .push (coreWrite), .pushData (coreData), .pop (rxPop),
        .popData (rxData), .full (rxFull), .empty (rxEmpty), .overflow (rxOverflow)
    );

    sclkDivider sclkDivider (
        .clk, .reset, .busy (!idle), .divider, .finalCycle
    );

    spiController spiController (
        .clk, .reset, .clockPolarity, .clockPhase, .order, .finalCycle,
        .dataIn (txHead), .dataOut (coreData), .coreTxEmpty (txEmpty),
        .coreWrite, .coreRead, .idle, .miso, .mosi, .sclk
    );

endmodule

/* logic/spiMaster_defs.svh */
`ifndef SPIMASTER_DEFS_SVH
`define SPIMASTER_DEFS_SVH

// serial byte width
`define SPI_DATAWIDTH 8

// entries in each byte fifo (power of two)
`define SPI_FIFODEPTH 4
`define SPI_PTRWIDTH  2     // log2 of fifo depth

// width of the divider value, half-period lasts divider+1 clocks
`define SPI_DIVWIDTH  8

`endif

/* spiMaster.f */
+incdir+logic
logic/spiCorePkg.sv
logic/hostBusPkg.sv
logic/byteFifo.sv
logic/sclkDivider.sv
logic/spiController.sv
logic/hostPort.sv
logic/spiMaster.sv
verification/spiMaster_chk.sv
verification/spiMasterTb.sv

/* verification/spiMasterTb.sv */
`timescale 1ns/100ps
`include "spiMaster_defs.svh"

module spiMasterTb import hostBusPkg::*, spiCorePkg::*; ();

    logic                       clk;
    logic                       reset;
    logic                       req;
    hostOp                      op;
    logic [`SPI_DATAWIDTH-1:0]  wdata;
    logic [`SPI_DIVWIDTH-1:0]   cfgDiv;
    logic                       ack;
    logic [`SPI_DATAWIDTH-1:0]  rdata;
    logic                       miso;
    logic                       mosi;
    logic                       sclk;
    logic                       ssN;

    int                         seed = 4;
    logic [`SPI_DATAWIDTH-1:0]  reply;       // byte the slave is shifting out
    logic [`SPI_DATAWIDTH-1:0]  captured;    // byte the slave is shifting in
    int                         sampleCnt;
    int                         bitIdx;
    logic                       cfgPol;
    logic                       cfgPha;
    bitOrder                    cfgOrd;
    logic [`SPI_DIVWIDTH-1:0]   curDiv;
    logic                       configuring; // polarity change glitches sclk
    logic [`SPI_DATAWIDTH-1:0]  txExp[$];
    logic [`SPI_DATAWIDTH-1:0]  rxExp[$];
    int                         opList[$];
    int                         argList[$];
    int                         divList[$];
    int                         expList[$];
    int                         maxDiv = 0;
    logic                       loaded = 1'b0;

    spiMaster i_dut (.*);
    bind spiMaster spiMaster_chk chk (.*);

    always #20 clk = ~clk;

    function automatic logic [`SPI_DATAWIDTH-1:0] nextReply();
        seed = seed * 1103515245 + 12345;  // lcg
        return seed[23:16];
    endfunction

    function automatic logic misoBit();
        return (cfgOrd == LSB_FIRST) ? reply[sampleCnt] : reply[`SPI_DATAWIDTH-1-sampleCnt];
    endfunction

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkByte(input string name, input logic [`SPI_DATAWIDTH-1:0] expected,
                             input logic [`SPI_DATAWIDTH-1:0] actual);
        if (actual !== expected)
            abortRun($sformatf("MISMATCH %s expected %02h actual %02h", name, expected, actual));
    endtask

    task automatic checkStatus(input string name, input logic [`SPI_DATAWIDTH-1:0] expected,
                               input logic [`SPI_DATAWIDTH-1:0] actual);
        string    bits;
        statusBit sb;
        bits = "";
        for (int b = 0; b <= int'(ST_IDLE); b++) begin
            if (actual[b] !== expected[b]) begin
                sb   = statusBit'(b);
                bits = {bits, " ", sb.name()};  // which flags differ
            end
        end
        if (actual !== expected)
            abortRun($sformatf("MISMATCH %s expected %02h actual %02h (%s )",
                               name, expected, actual, bits));
    endtask

    // one four-phase handshake sampled 2 ns after each edge
    task automatic hostCmd(input hostOp c, input logic [`SPI_DATAWIDTH-1:0] arg,
                           input logic [`SPI_DIVWIDTH-1:0] dv,
                           output logic [`SPI_DATAWIDTH-1:0] result);
        @(posedge clk);
        #2;
        op     = c;
        wdata  = arg;
        cfgDiv = dv;
        req    = 1'b1;
        do begin  // back-pressure may stretch this
            @(posedge clk);
            #2;
        end while (!ack);
        result = rdata;
        req    = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (ack);
    endtask

    task automatic loadStimulus();
        int    fd;
        int    a, b, c, d;
        string line;
        fd = $fopen("verification/spiMaster_stimulus.txt", "r");
        if (fd == 0)
            abortRun("cannot open the stimulus file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h", a, b, c, d) == 4) begin  // comments fail here
                opList.push_back(a);
                argList.push_back(b);
                divList.push_back(c);
                expList.push_back(d);
                if (c > maxDiv)
                    maxDiv = c;
            end
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    task automatic runLine(input int i);
        hostOp                      c;
        logic [`SPI_DATAWIDTH-1:0]  arg;
        logic [`SPI_DATAWIDTH-1:0]  res;
        string                      name;
        c    = hostOp'(opList[i][2:0]);
        arg  = argList[i][`SPI_DATAWIDTH-1:0];
        name = $sformatf("line %0d %s", i, c.name());
        case (c)
            OP_WRITE_TX: begin
                txExp.push_back(arg);       // slave must see this byte
                hostCmd(c, arg, '0, res);
            end
            OP_READ_RX: begin
                hostCmd(c, arg, '0, res);
                if (rxExp.size() == 0)
                    abortRun({name, ": read returned a byte the slave never sent"});
                checkByte(name, rxExp.pop_front(), res);
            end
            OP_SET_CONFIG: begin
                configuring = 1'b1;
                hostCmd(c, arg, divList[i][`SPI_DIVWIDTH-1:0], res);
                cfgPol      = arg[0];
                cfgPha      = arg[1];
                cfgOrd      = bitOrder'(arg[2]);
                curDiv      = divList[i][`SPI_DIVWIDTH-1:0];
                miso        = misoBit();    // first bit in the new order
                configuring = 1'b0;
            end
            OP_READ_STATUS: begin
                while (txExp.size() != 0) @(posedge clk);
                repeat (2 * (curDiv + 1) + 4) @(posedge clk);  // STOP half-period
                hostCmd(c, arg, '0, res);
                checkStatus(name, expList[i][`SPI_DATAWIDTH-1:0], res);
            end
            default: hostCmd(c, arg, '0, res);
        endcase
    endtask

    // spi slave samples on the leading edge in phase 0 and the trailing edge in phase 1
    always @(sclk) begin
        if (!reset && !ssN && !configuring && ((sclk != cfgPol) != cfgPha)) begin
            bitIdx = (cfgOrd == LSB_FIRST) ? sampleCnt : `SPI_DATAWIDTH-1-sampleCnt;
            captured[bitIdx] = mosi;
            sampleCnt++;
            if (sampleCnt == `SPI_DATAWIDTH) begin
                sampleCnt = 0;
                if (txExp.size() == 0)
                    abortRun("slave received a byte that was never written");
                checkByte("mosi capture", txExp.pop_front(), captured);
                if (rxExp.size() < `SPI_FIFODEPTH)
                    rxExp.push_back(reply);  // else the dut drops it
                reply = nextReply();
            end
            miso = misoBit();
        end
    end

    // stop at the first failed protocol assertion
    always @(i_dut.chk.failCount) begin
        if (i_dut.chk.failCount != 0)
            abortRun("a protocol assertion failed");
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(opList.size()) * 16 * (maxDiv + 2) * 40 + 50000;
        #(limit);
        abortRun("watchdog expired before the stimulus finished");
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        op          = OP_READ_STATUS;
        wdata       = '0;
        cfgDiv      = '0;
        configuring = 1'b0;
        cfgPol      = 1'b0;
        cfgPha      = 1'b0;
        cfgOrd      = MSB_FIRST;
        curDiv      = '0;
        sampleCnt   = 0;
        reply       = nextReply();
        miso        = misoBit();
        loadStimulus();
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        checkByte("reset pins", 8'h01, {6'b0, sclk, ssN});
        for (int i = 0; i < opList.size(); i++)
            runLine(i);
        if (txExp.size() != 0 || rxExp.size() != 0)
            abortRun("bytes left unchecked at end of stimulus");
        if (i_dut.chk.failCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abortRun("protocol assertions failed");
        end
    end

endmodule

/* verification/spiMaster_chk.sv */
`timescale 1ns/100ps

module spiMaster_chk (
    input logic clk,
    input logic reset,
    input logic req,
    input logic ack,
    input logic sclk,
    input logic ssN,
    input logic idle,
    input logic clockPolarity
);

    int failCount = 0;  // failed assertions so far

    // req was still up on the edge that raised ack
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            failCount++;
        end

    // host releases req only once ack is up
    reqHeldForAck: assert property (@(posedge clk) disable iff (reset)
        $fell(req) |-> ack)
        else begin
            $error("req dropped before ack");
            failCount++;
        end

    // polarity just written takes one cycle to reach the pin
    sclkRestsIdle: assert property (@(posedge clk) disable iff (reset)
        (idle && $stable(clockPolarity)) |-> (sclk == clockPolarity))
        else begin
            $error("sclk off its rest level while idle");
            failCount++;
        end

    ssnOnlyIdle: assert property (@(posedge clk) disable iff (reset)
        !$stable(ssN) |-> $past(idle))
        else begin
            $error("ssN changed during a transfer");
            failCount++;
        end

endmodule

/* verification/spiMaster_stimulus.txt */
# columns: opcode operand cfgDiv expected, all hex
# opcodes: 0 write tx, 1 read rx, 2 config, 3 select, 4 status
4 00 00 2A
2 00 03 00
3 00 00 00
0 A5 00 00
1 00 00 00
2 01 02 00
0 3C 00 00
1 00 00 00
2 02 01 00
0 C3 00 00
1 00 00 00
2 03 00 00
0 5A 00 00
1 00 00 00
2 04 02 00
0 81 00 00
1 00 00 00
0 11 00 00
0 22 00 00
0 33 00 00
0 44 00 00
0 55 00 00
1 00 00 00
1 00 00 00
1 00 00 00
1 00 00 00
1 00 00 00
4 00 00 2A
0 01 00 00
0 02 00 00
0 03 00 00
0 04 00 00
0 05 00 00
0 06 00 00
4 00 00 36
4 00 00 26
1 00 00 00
1 00 00 00
1 00 00 00
1 00 00 00
3 01 00 00
